//--- dv/core_tests.txt
# I <instruction word hex>   program in fetch order, word n at address 4*n
# R <rd hex> <data hex>       expected retire in order;  C <count> number of R lines
I 20000000  AND r0, r0, #0 (imm12)
I 030100FF  ADD r1, r0, #0xFF ror 0
I 0302013F  ADD r2, r0, #0x3F ror 2
I 21130AB0  OR  r3, r1, #0xAB0 (imm12)
I 003400F0  AND r4, r3, #0xF0 ror 0
I 02250401  SUB r5, r2, #0x01 ror 8
I 23460FFF  ADD r6, r4, #0xFFF (imm12)
I 01070F80  OR  r7, r0, #0x80 ror 30
I 33080202  ADD r8, r0, r2 LSL 4
I 33090422  ADD r9, r0, r2 LSR 8
I 330A0242  ADD r10, r0, r2 ASR 4
I 330B0662  ADD r11, r0, r2 ROR 12
I 129C0001  SUB r12, r9, r1
I 311D0F81  OR  r13, r1, r1 LSL 31
I 23010005  ADD r1, r0, #5
I 23120003  ADD r2, r1, #3         distance 1
I 23030001  ADD r3, r0, #1
I 12140002  SUB r4, r1, r2         distances 3 and 2
I 33450084  ADD r5, r4, r4 LSL 1   distance 1 on both
I C0000000  NOP
I 23060040  ADD r6, r0, #0x40      data base
I 21B705A3  OR  r7, r11, #0x5A3
I A0670004  STR  r7, [r6, #4]
I A0658005  STRB r5, [r6, #5]
I 60680004  LDR  r8, [r6, #4]
I 23890001  ADD r9, r8, #1         load use
I 400A8045  LDRB r10, [r0, #0x45]
I 22AB00F0  SUB r11, r10, #0xF0    load use
I 606C8007  LDRB r12, [r6, #7]
I 13CD0008  ADD r13, r12, r8       load use
R 0 00000000
R 1 000000FF
R 2 C000000F
R 3 00000AFF
R 4 000000F0
R 5 BF00000F
R 6 000010EF
R 7 00000200
R 8 000000F0
R 9 00C00000
R A FC000000
R B 00FC0000
R C 00BFFF01
R D 800000FF
R 1 00000005
R 2 00000008
R 3 00000001
R 4 FFFFFFFD
R 5 FFFFFFF7
R 6 00000040
R 7 00FC05A3
R 8 00F705A3
R 9 00F705A4
R A 000000F7
R B 00000007
R C 000000A3
R D 00F70646
C 27

//--- vlog.f
design/core_pkg.sv
design/fetch_stage.sv
design/register_file.sv
design/hazard_unit.sv
design/decode_stage.sv
design/execute_stage.sv
design/memory_stage.sv
design/pipeline_core.sv
dv/core_tb.sv

//--- Makefile
TOP = core_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f vlog.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f vlog.f
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

//--- dv/core_tb.sv
// Runs from the project root; reads dv/core_tests.txt, then runs it bare and with random waits
`default_nettype none

module core_tb;

  localparam int              RETIRE_TIMEOUT = 64; // Cycles allowed between two retires
  localparam int              QUIET_CYCLES   = 30;
  localparam core_pkg::word_t NOP_WORD       = {core_pkg::KIND_NOP, 30'b0};

  logic                 clk;
  logic                 reset;
  logic                 wb_cyc;
  logic                 wb_stb;
  logic                 wb_we;
  core_pkg::word_t      wb_adr;
  logic                 wb_ack;
  core_pkg::word_t      wb_dat_i;
  logic                 retire_valid;
  core_pkg::reg_idx_t   retire_rd;
  core_pkg::word_t      retire_data;

  core_pkg::word_t      prog [$];     // Program image, one word per fetch address
  core_pkg::reg_idx_t   exp_rd [$];
  core_pkg::word_t      exp_data [$];
  int                   exp_count = -1;
  int                   seed;
  int                   wait_cnt;
  int                   extra;
  logic                 req_open;
  logic                 random_waits; // 0 to 3 wait states per fetch when set
  core_pkg::word_t      next_pc;

  pipeline_core pipeline_core_i (
    .clk          (clk),
    .reset        (reset),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_we        (wb_we),
    .wb_adr       (wb_adr),
    .wb_ack       (wb_ack),
    .wb_dat_i     (wb_dat_i),
    .retire_valid (retire_valid),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check_rd(input string name, input core_pkg::reg_idx_t got,
                          input core_pkg::reg_idx_t exp);
    if (got !== exp)
      report_failure($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic check_data(input string name, input core_pkg::word_t got,
                            input core_pkg::word_t exp);
    if (got !== exp)
      report_failure($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
      report_failure($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  // Word at adr / PC_STEP, NOP once past the program
  function automatic core_pkg::word_t fetch_word(input core_pkg::word_t adr);
    int idx;
    idx = int'(adr / core_pkg::PC_STEP);
    if (idx < prog.size())
      return prog[idx];
    return NOP_WORD;
  endfunction

  task automatic load_tests();
    int              fd;
    int              n;
    int              rd_val;
    core_pkg::word_t w;
    string           line;
    string           rest;
    byte             tag;
    fd = $fopen("dv/core_tests.txt", "r");
    if (fd == 0)
      report_failure("Could not open the test data file dv/core_tests.txt");
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (line.len() < 3)
        continue;
      tag  = line.getc(0); // First column selects the line kind
      rest = line.substr(2, line.len() - 1);
      if (tag == "I") begin
        n = $sscanf(rest, "%h", w);
        if (n != 1)
          report_failure($sformatf("Malformed program line: %s", line));
        prog.push_back(w);
      end else if (tag == "R") begin
        n = $sscanf(rest, "%h %h", rd_val, w);
        if (n != 2)
          report_failure($sformatf("Malformed retire line: %s", line));
        exp_rd.push_back(core_pkg::reg_idx_t'(rd_val));
        exp_data.push_back(w);
      end else if (tag == "C") begin
        n = $sscanf(rest, "%d", exp_count);
      end
    end
    $fclose(fd);
    if (prog.size() == 0 || exp_count != exp_rd.size())
      report_failure("Test data file has no program or a wrong retire count");
  endtask

  task automatic wait_retire();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!retire_valid) begin
      if (cycles == RETIRE_TIMEOUT)
        report_failure("Timed out waiting for the next instruction to retire");
      cycles++;
      @(negedge clk);
    end
  endtask

  // Wishbone slave, answers on the falling edge
  initial begin
    seed     = 32'h521d;
    wb_ack   = 1'b0;
    wb_dat_i = '0;
    req_open = 1'b0;
    wait_cnt = 0;
    next_pc  = core_pkg::RESET_PC;
    forever begin
      @(negedge clk);
      wb_ack = 1'b0;
      if (reset) begin
        req_open = 1'b0; // Reset drops any open request
        next_pc  = core_pkg::RESET_PC;
      end else if (wb_stb) begin
        check_bit("wb_cyc", wb_cyc, 1'b1);
        check_bit("wb_we", wb_we, 1'b0);
        if (!req_open) begin
          req_open = 1'b1;
          check_data("wb_adr", wb_adr, next_pc); // Sequential fetch order
          wait_cnt = random_waits ? $unsigned($random(seed)) % 4 : 0;
        end
        if (wait_cnt == 0) begin
          wb_ack   = 1'b1;
          wb_dat_i = fetch_word(wb_adr);
          req_open = 1'b0;
          next_pc  = next_pc + core_pkg::PC_STEP;
        end else begin
          wait_cnt = wait_cnt - 1;
        end
      end
    end
  end

  initial begin
    random_waits = 1'b0;
    reset        = 1'b1;
    load_tests();
    // First run without wait states keeps dependent instructions adjacent
    for (int pass = 0; pass < 2; pass++) begin
      random_waits = (pass == 1);
      reset        = 1'b1;
      for (int i = 0; i < 3; i++) begin
        @(negedge clk);
        check_bit("wb_cyc", wb_cyc, 1'b0);
        check_bit("wb_stb", wb_stb, 1'b0);
        check_bit("retire_valid", retire_valid, 1'b0);
      end
      reset = 1'b0;
      @(negedge clk); // First request is due one cycle after reset
      check_bit("wb_stb", wb_stb, 1'b1);
      check_data("wb_adr", wb_adr, core_pkg::RESET_PC);

      for (int i = 0; i < exp_count; i++) begin
        wait_retire();
        check_rd($sformatf("retire_rd[%0d]", i), retire_rd, exp_rd[i]);
        check_data($sformatf("retire_data[%0d]", i), retire_data, exp_data[i]);
      end

      // Only NOPs follow the program, so nothing more may retire
      extra = 0;
      repeat (QUIET_CYCLES) begin
        @(negedge clk);
        if (retire_valid)
          extra++;
      end
      if (extra != 0)
        report_failure($sformatf("%0d instructions retired after the end of the program", extra));
    end
    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

//--- design/pipeline_core.sv
// Five-stage core top; instruction fetch over Wishbone, data memory internal, no branches
`default_nettype none

module pipeline_core (
  input  logic               clk,
  input  logic               reset,
  output logic               wb_cyc,
  output logic               wb_stb,
  output logic               wb_we,
  output core_pkg::word_t    wb_adr,
  input  logic               wb_ack,
  input  core_pkg::word_t    wb_dat_i,
  output logic               retire_valid,
  output core_pkg::reg_idx_t retire_rd,
  output core_pkg::word_t    retire_data
);

  logic                  stall;
  logic                  id_valid;
  core_pkg::word_t       id_instr;
  logic                  ex_valid;
  core_pkg::instr_kind_t ex_kind;
  core_pkg::alu_op_t     ex_op;
  core_pkg::addr_mode_t  ex_mode;
  logic                  ex_byte;
  core_pkg::reg_idx_t    ex_rd_idx;
  core_pkg::word_t       ex_opnd_n;
  core_pkg::word_t       ex_opnd_m;
  core_pkg::word_t       ex_store_data;
  core_pkg::opnd_field_t ex_field;
  logic                  ex_we_hint;
  core_pkg::reg_idx_t    ex_dest;
  core_pkg::word_t       ex_result;
  logic                  ex_is_load;
  logic                  mem_valid;
  core_pkg::instr_kind_t mem_kind;
  logic                  mem_byte;
  core_pkg::reg_idx_t    mem_rd_idx;
  core_pkg::word_t       exmem_result;
  core_pkg::word_t       mem_store_data;
  logic                  mem_we;
  core_pkg::reg_idx_t    mem_dest;
  core_pkg::word_t       mem_fwd_data;

  fetch_stage fetch_stage_i (
    .clk      (clk),
    .reset    (reset),
    .stall    (stall),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_ack   (wb_ack),
    .wb_dat_i (wb_dat_i),
    .id_valid (id_valid),
    .id_instr (id_instr)
  );

  decode_stage decode_stage_i (
    .clk           (clk),
    .reset         (reset),
    .id_valid      (id_valid),
    .id_instr      (id_instr),
    .ex_result     (ex_result),
    .mem_result    (mem_fwd_data),
    .wb_result     (retire_data),
    .wb_we         (retire_valid), // Register write, not the bus signal
    .wb_rd         (retire_rd),
    .stall         (stall),
    .ex_we         (ex_we_hint),
    .mem_we        (mem_we),
    .ex_rd         (ex_dest),
    .mem_rd        (mem_dest),
    .ex_load       (ex_is_load),
    .ex_valid      (ex_valid),
    .ex_kind       (ex_kind),
    .ex_op         (ex_op),
    .ex_mode       (ex_mode),
    .ex_byte       (ex_byte),
    .ex_rd_idx     (ex_rd_idx),
    .ex_opnd_n     (ex_opnd_n),
    .ex_opnd_m     (ex_opnd_m),
    .ex_store_data (ex_store_data),
    .ex_field      (ex_field)
  );

  execute_stage execute_stage_i (
    .clk            (clk),
    .reset          (reset),
    .ex_valid       (ex_valid),
    .ex_kind        (ex_kind),
    .ex_op          (ex_op),
    .ex_mode        (ex_mode),
    .ex_byte        (ex_byte),
    .ex_rd_idx      (ex_rd_idx),
    .ex_opnd_n      (ex_opnd_n),
    .ex_opnd_m      (ex_opnd_m),
    .ex_store_data  (ex_store_data),
    .ex_field       (ex_field),
    .ex_we_hint     (ex_we_hint),
    .ex_dest        (ex_dest),
    .ex_result      (ex_result),
    .ex_is_load     (ex_is_load),
    .mem_valid      (mem_valid),
    .mem_kind       (mem_kind),
    .mem_byte       (mem_byte),
    .mem_rd_idx     (mem_rd_idx),
    .mem_result     (exmem_result),
    .mem_store_data (mem_store_data)
  );

  memory_stage memory_stage_i (
    .clk            (clk),
    .reset          (reset),
    .mem_valid      (mem_valid),
    .mem_kind       (mem_kind),
    .mem_byte       (mem_byte),
    .mem_rd_idx     (mem_rd_idx),
    .mem_result     (exmem_result),
    .mem_store_data (mem_store_data),
    .mem_we         (mem_we),
    .mem_dest       (mem_dest),
    .mem_fwd_data   (mem_fwd_data),
    .retire_valid   (retire_valid),
    .retire_rd      (retire_rd),
    .retire_data    (retire_data)
  );

endmodule

`default_nettype wire

//--- design/memory_stage.sv
// 256-byte big-endian data memory, same-cycle read; addresses wrap and memory has no reset
`default_nettype none

module memory_stage (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  mem_valid,
  input  core_pkg::instr_kind_t mem_kind,
  input  logic                  mem_byte,
  input  core_pkg::reg_idx_t    mem_rd_idx,
  input  core_pkg::word_t       mem_result,
  input  core_pkg::word_t       mem_store_data,
  output logic                  mem_we,
  output core_pkg::reg_idx_t    mem_dest,
  output core_pkg::word_t       mem_fwd_data,
  output logic                  retire_valid,
  output core_pkg::reg_idx_t    retire_rd,
  output core_pkg::word_t       retire_data
);

  logic [7:0]          dmem [core_pkg::DMEM_BYTES];
  core_pkg::mem_addr_t addr;
  core_pkg::word_t     load_data;
  logic                store_en;

  assign addr     = mem_result[$bits(core_pkg::mem_addr_t)-1:0];
  assign store_en = mem_valid && mem_kind == core_pkg::KIND_STORE;

  // Most significant byte at the lowest address
  assign load_data = mem_byte ? {24'b0, dmem[addr]}
                              : {dmem[addr], dmem[addr + 8'd1],
                                 dmem[addr + 8'd2], dmem[addr + 8'd3]};

  always_ff @(posedge clk) begin
    if (store_en) begin
      if (mem_byte) begin
        dmem[addr] <= mem_store_data[7:0];
      end else begin
        dmem[addr]        <= mem_store_data[31:24];
        dmem[addr + 8'd1] <= mem_store_data[23:16];
        dmem[addr + 8'd2] <= mem_store_data[15:8];
        dmem[addr + 8'd3] <= mem_store_data[7:0];
      end
    end
  end

  assign mem_we       = mem_valid && mem_kind != core_pkg::KIND_STORE;
  assign mem_dest     = mem_rd_idx;
  assign mem_fwd_data = (mem_kind == core_pkg::KIND_LOAD) ? load_data : mem_result;

  always_ff @(posedge clk or posedge reset) begin
    if (reset)
      retire_valid <= 1'b0;
    else
      retire_valid <= mem_we;
  end

  always_ff @(posedge clk) begin
    retire_rd   <= mem_rd_idx;
    retire_data <= mem_fwd_data; // Also the WB forward value
  end

  a_bubble_no_write: assert property (@(posedge clk) disable iff (reset)
    !mem_valid |=> dmem[$past(addr)] == $past(dmem[addr]));

endmodule

`default_nettype wire

//--- design/execute_stage.sv
// Shifter operand and ALU; loads and stores always add, and the ALU sets no flags
`default_nettype none

module execute_stage (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  ex_valid,
  input  core_pkg::instr_kind_t ex_kind,
  input  core_pkg::alu_op_t     ex_op,
  input  core_pkg::addr_mode_t  ex_mode,
  input  logic                  ex_byte,
  input  core_pkg::reg_idx_t    ex_rd_idx,
  input  core_pkg::word_t       ex_opnd_n,
  input  core_pkg::word_t       ex_opnd_m,
  input  core_pkg::word_t       ex_store_data,
  input  core_pkg::opnd_field_t ex_field,
  output logic                  ex_we_hint,
  output core_pkg::reg_idx_t    ex_dest,
  output core_pkg::word_t       ex_result,
  output logic                  ex_is_load,
  output logic                  mem_valid,
  output core_pkg::instr_kind_t mem_kind,
  output logic                  mem_byte,
  output core_pkg::reg_idx_t    mem_rd_idx,
  output core_pkg::word_t       mem_result,
  output core_pkg::word_t       mem_store_data
);

  core_pkg::shift_t  sh_type;
  core_pkg::alu_op_t op;
  core_pkg::word_t   shift_opnd;
  logic [4:0]        sh_amt;
  logic [63:0]       rot_pair;
  logic [63:0]       rm_pair;

  assign sh_type  = ex_field[core_pkg::SHTYPE_POS +: $bits(sh_type)];
  assign sh_amt   = ex_field[core_pkg::SHAMT_POS +: 5];
  // Rotates done as a right shift of the doubled word
  assign rot_pair = {2{{24'b0, ex_field[7:0]}}} >> {ex_field[core_pkg::ROT_POS +: 4], 1'b0};
  assign rm_pair  = {ex_opnd_m, ex_opnd_m} >> sh_amt;

  always_comb begin
    case (ex_mode)
      core_pkg::AM_ROT_IMM: shift_opnd = rot_pair[31:0];
      core_pkg::AM_REG:     shift_opnd = ex_opnd_m;
      core_pkg::AM_IMM12:   shift_opnd = {20'b0, ex_field};
      default: begin
        case (sh_type)
          core_pkg::SH_LSL: shift_opnd = ex_opnd_m << sh_amt;
          core_pkg::SH_LSR: shift_opnd = ex_opnd_m >> sh_amt;
          core_pkg::SH_ASR: shift_opnd = $signed(ex_opnd_m) >>> sh_amt;
          default:          shift_opnd = rm_pair[31:0];
        endcase
      end
    endcase
  end

  assign op = (ex_kind == core_pkg::KIND_DP) ? ex_op : core_pkg::ALU_ADD; // Address calc

  always_comb begin
    case (op)
      core_pkg::ALU_AND: ex_result = ex_opnd_n & shift_opnd;
      core_pkg::ALU_OR:  ex_result = ex_opnd_n | shift_opnd;
      core_pkg::ALU_SUB: ex_result = ex_opnd_n - shift_opnd;
      core_pkg::ALU_ADD: ex_result = ex_opnd_n + shift_opnd;
      default:           ex_result = '0;
    endcase
  end

  assign ex_dest    = ex_rd_idx;
  assign ex_we_hint = ex_valid && ex_kind != core_pkg::KIND_STORE;
  assign ex_is_load = ex_valid && ex_kind == core_pkg::KIND_LOAD;

  always_ff @(posedge clk or posedge reset) begin
    if (reset)
      mem_valid <= 1'b0;
    else
      mem_valid <= ex_valid;
  end

  always_ff @(posedge clk) begin
    mem_kind       <= ex_kind;
    mem_byte       <= ex_byte;
    mem_rd_idx     <= ex_rd_idx;
    mem_result     <= ex_result;
    mem_store_data <= ex_store_data;
  end

endmodule

`default_nettype wire

//--- design/decode_stage.sv
// Decode with three-source forwarding; NOPs leave as bubbles and never reach the retire port
`default_nettype none

module decode_stage (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  id_valid,
  input  core_pkg::word_t       id_instr,
  input  core_pkg::word_t       ex_result,
  input  core_pkg::word_t       mem_result,
  input  core_pkg::word_t       wb_result,
  input  logic                  wb_we,
  input  core_pkg::reg_idx_t    wb_rd,
  output logic                  stall,
  input  logic                  ex_we,
  input  logic                  mem_we,
  input  core_pkg::reg_idx_t    ex_rd,
  input  core_pkg::reg_idx_t    mem_rd,
  input  logic                  ex_load,
  output logic                  ex_valid,
  output core_pkg::instr_kind_t ex_kind,
  output core_pkg::alu_op_t     ex_op,
  output core_pkg::addr_mode_t  ex_mode,
  output logic                  ex_byte,
  output core_pkg::reg_idx_t    ex_rd_idx,
  output core_pkg::word_t       ex_opnd_n,
  output core_pkg::word_t       ex_opnd_m,
  output core_pkg::word_t       ex_store_data,
  output core_pkg::opnd_field_t ex_field
);

  core_pkg::instr_kind_t kind;
  core_pkg::addr_mode_t  mode;
  core_pkg::opnd_field_t field;
  core_pkg::reg_idx_t    rn;
  core_pkg::reg_idx_t    rm;
  core_pkg::reg_idx_t    rd;
  core_pkg::word_t       rf_n;
  core_pkg::word_t       rf_m;
  core_pkg::word_t       rf_d;
  core_pkg::fwd_sel_t    fwd_n;
  core_pkg::fwd_sel_t    fwd_m;
  core_pkg::fwd_sel_t    fwd_d;
  logic                  active;
  logic                  use_m;
  logic                  use_d;
  logic                  hz_stall;

  function automatic core_pkg::word_t fwd_mux(
    input core_pkg::fwd_sel_t sel,
    input core_pkg::word_t rf, ex, mem, wb
  );
    case (sel)
      core_pkg::FWD_EX:  return ex;
      core_pkg::FWD_MEM: return mem;
      core_pkg::FWD_WB:  return wb;
      default:           return rf;
    endcase
  endfunction

  assign kind  = (id_instr == '0) ? core_pkg::KIND_NOP
                                  : id_instr[core_pkg::KIND_POS +: $bits(kind)];
  assign mode  = id_instr[core_pkg::MODE_POS +: $bits(mode)];
  assign field = id_instr[core_pkg::FIELD_POS +: $bits(field)];
  assign rn    = id_instr[core_pkg::RN_POS +: $bits(rn)];
  assign rd    = id_instr[core_pkg::RD_POS +: $bits(rd)];
  assign rm    = field[core_pkg::RM_POS +: $bits(rm)];

  assign active = id_valid && kind != core_pkg::KIND_NOP;
  assign use_m  = active && (mode == core_pkg::AM_REG || mode == core_pkg::AM_SHIFT_REG);
  assign use_d  = active && kind == core_pkg::KIND_STORE;
  assign stall  = hz_stall && active; // Rn is read by every real instruction

  register_file register_file_i (
    .clk       (clk),
    .we        (wb_we),
    .wr_idx    (wb_rd),
    .wr_data   (wb_result),
    .rd_idx_a  (rn),
    .rd_idx_b  (rm),
    .rd_idx_c  (rd),
    .rd_data_a (rf_n),
    .rd_data_b (rf_m),
    .rd_data_c (rf_d)
  );

  hazard_unit hazard_unit_i (
    .src_n   (rn),
    .src_m   (rm),
    .src_d   (rd),
    .use_m   (use_m),
    .use_d   (use_d),
    .ex_we   (ex_we),
    .mem_we  (mem_we),
    .wb_we   (wb_we),
    .ex_rd   (ex_rd),
    .mem_rd  (mem_rd),
    .wb_rd   (wb_rd),
    .ex_load (ex_load),
    .fwd_n   (fwd_n),
    .fwd_m   (fwd_m),
    .fwd_d   (fwd_d),
    .stall   (hz_stall)
  );

  always_ff @(posedge clk or posedge reset) begin
    if (reset)
      ex_valid <= 1'b0;
    else
      ex_valid <= active && !stall; // Bubble while stalled
  end

  always_ff @(posedge clk) begin
    ex_kind       <= kind;
    ex_op         <= id_instr[core_pkg::OP_POS +: $bits(ex_op)];
    ex_mode       <= mode;
    ex_byte       <= id_instr[core_pkg::BYTE_POS];
    ex_rd_idx     <= rd;
    ex_field      <= field;
    ex_opnd_n     <= fwd_mux(fwd_n, rf_n, ex_result, mem_result, wb_result);
    ex_opnd_m     <= fwd_mux(fwd_m, rf_m, ex_result, mem_result, wb_result);
    ex_store_data <= fwd_mux(fwd_d, rf_d, ex_result, mem_result, wb_result);
  end

  // The stalling load moves on to MEM behind a bubble, so the stall cannot repeat
  a_stall_once: assert property (@(posedge clk) disable iff (reset) stall |=> !stall);

endmodule

`default_nettype wire

//--- design/hazard_unit.sv
// Forward selection and load-use detection; caller must gate the Rn compare for bubbles and NOPs
`default_nettype none

module hazard_unit (
  input  core_pkg::reg_idx_t src_n,
  input  core_pkg::reg_idx_t src_m,
  input  core_pkg::reg_idx_t src_d,
  input  logic               use_m,
  input  logic               use_d,
  input  logic               ex_we,
  input  logic               mem_we,
  input  logic               wb_we,
  input  core_pkg::reg_idx_t ex_rd,
  input  core_pkg::reg_idx_t mem_rd,
  input  core_pkg::reg_idx_t wb_rd,
  input  logic               ex_load,
  output core_pkg::fwd_sel_t fwd_n,
  output core_pkg::fwd_sel_t fwd_m,
  output core_pkg::fwd_sel_t fwd_d,
  output logic               stall
);

  // Youngest producer wins
  function automatic core_pkg::fwd_sel_t pick(
    input core_pkg::reg_idx_t src,
    input logic ew, mw, ww,
    input core_pkg::reg_idx_t er, mr, wr
  );
    if (ew && src == er)
      return core_pkg::FWD_EX;
    if (mw && src == mr)
      return core_pkg::FWD_MEM;
    if (ww && src == wr)
      return core_pkg::FWD_WB;
    return core_pkg::FWD_NONE;
  endfunction

  assign fwd_n = pick(src_n, ex_we, mem_we, wb_we, ex_rd, mem_rd, wb_rd);
  assign fwd_m = use_m ? pick(src_m, ex_we, mem_we, wb_we, ex_rd, mem_rd, wb_rd)
                       : core_pkg::FWD_NONE;
  assign fwd_d = use_d ? pick(src_d, ex_we, mem_we, wb_we, ex_rd, mem_rd, wb_rd)
                       : core_pkg::FWD_NONE; // Store data only

  // Load data exists only from MEM onward
  assign stall = ex_load && ex_we &&
                 (src_n == ex_rd || (use_m && src_m == ex_rd) || (use_d && src_d == ex_rd));

endmodule

`default_nettype wire

//--- design/register_file.sv
// Sixteen general registers with no reset; contents are undefined until software writes them
`default_nettype none

module register_file (
  input  logic               clk,
  input  logic               we,
  input  core_pkg::reg_idx_t wr_idx,
  input  core_pkg::word_t    wr_data,
  input  core_pkg::reg_idx_t rd_idx_a,
  input  core_pkg::reg_idx_t rd_idx_b,
  input  core_pkg::reg_idx_t rd_idx_c,
  output core_pkg::word_t    rd_data_a,
  output core_pkg::word_t    rd_data_b,
  output core_pkg::word_t    rd_data_c
);

  core_pkg::word_t regs [2**$bits(core_pkg::reg_idx_t)];

  always_ff @(posedge clk) begin
    if (we)
      regs[wr_idx] <= wr_data;
  end

  // Reads see the old value in the write cycle, WB forwarding covers that
  assign rd_data_a = regs[rd_idx_a];
  assign rd_data_b = regs[rd_idx_b];
  assign rd_data_c = regs[rd_idx_c];

endmodule

`default_nettype wire

//--- design/fetch_stage.sv
// Wishbone classic read-only fetch master; one skid entry absorbs an ack that lands during stall
`default_nettype none

module fetch_stage (
  input  logic            clk,
  input  logic            reset,
  input  logic            stall,
  output logic            wb_cyc,
  output logic            wb_stb,
  output logic            wb_we,
  output core_pkg::word_t wb_adr,
  input  logic            wb_ack,
  input  core_pkg::word_t wb_dat_i,
  output logic            id_valid,
  output core_pkg::word_t id_instr
);

  typedef enum logic {FETCH_IDLE, FETCH_WAIT} fetch_state_t;

  fetch_state_t    state;
  core_pkg::word_t pc;
  core_pkg::word_t skid_instr;
  logic            skid_valid;
  logic            skid_next;
  logic            take;

  assign wb_cyc = (state == FETCH_WAIT);
  assign wb_stb = (state == FETCH_WAIT);
  assign wb_we  = 1'b0; // Fetch never writes
  assign wb_adr = pc;

  assign take = wb_stb && wb_ack;
  // Skid fills on an ack under stall and empties once stall drops
  assign skid_next = stall ? (skid_valid || take) : (skid_valid && take);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state      <= FETCH_IDLE;
      pc         <= core_pkg::RESET_PC;
      skid_valid <= 1'b0;
      id_valid   <= 1'b0;
    end else begin
      skid_valid <= skid_next;
      if (take)
        pc <= pc + core_pkg::PC_STEP;
      case (state)
        FETCH_IDLE: if (!skid_next) state <= FETCH_WAIT;
        FETCH_WAIT: if (take && skid_next) state <= FETCH_IDLE; // Pause while skid full
        default:    state <= FETCH_IDLE;
      endcase
      if (!stall)
        id_valid <= skid_valid || take;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall)
      id_instr <= skid_valid ? skid_instr : wb_dat_i; // Skid drains first
    if (take && (stall || skid_valid))
      skid_instr <= wb_dat_i;
  end

  a_req_hold: assert property (@(posedge clk) disable iff (reset)
    wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr));

endmodule

`default_nettype wire

//--- design/core_pkg.sv
// Shared encoding and constants for the five-stage core; no branches, flags or PC register file entry
`default_nettype none

package core_pkg;

  typedef logic [31:0] word_t;       // Data, address or instruction
  typedef logic [3:0]  reg_idx_t;    // Register number
  typedef logic [7:0]  mem_addr_t;   // Low byte of a data address
  typedef logic [11:0] opnd_field_t; // Shifter operand field
  typedef logic [3:0]  alu_op_t;
  typedef logic [1:0]  instr_kind_t;
  typedef logic [1:0]  addr_mode_t;
  typedef logic [1:0]  shift_t;
  typedef logic [1:0]  fwd_sel_t;

  localparam alu_op_t ALU_AND = 4'd0;
  localparam alu_op_t ALU_OR  = 4'd1;
  localparam alu_op_t ALU_SUB = 4'd2;
  localparam alu_op_t ALU_ADD = 4'd3; // Other codes give zero

  localparam instr_kind_t KIND_DP    = 2'd0;
  localparam instr_kind_t KIND_LOAD  = 2'd1;
  localparam instr_kind_t KIND_STORE = 2'd2;
  localparam instr_kind_t KIND_NOP   = 2'd3; // All-zero word is a NOP too

  localparam addr_mode_t AM_ROT_IMM   = 2'd0; // imm8 rotated right by 2*rot
  localparam addr_mode_t AM_REG       = 2'd1;
  localparam addr_mode_t AM_IMM12     = 2'd2; // Zero-extended
  localparam addr_mode_t AM_SHIFT_REG = 2'd3;

  localparam shift_t SH_LSL = 2'd0;
  localparam shift_t SH_LSR = 2'd1;
  localparam shift_t SH_ASR = 2'd2;
  localparam shift_t SH_ROR = 2'd3;

  localparam fwd_sel_t FWD_NONE = 2'd0;
  localparam fwd_sel_t FWD_EX   = 2'd1;
  localparam fwd_sel_t FWD_MEM  = 2'd2;
  localparam fwd_sel_t FWD_WB   = 2'd3;

  // Instruction field positions (LSB of each field)
  localparam int KIND_POS   = 30;
  localparam int MODE_POS   = 28;
  localparam int OP_POS     = 24;
  localparam int RN_POS     = 20;
  localparam int RD_POS     = 16;
  localparam int BYTE_POS   = 15; // Set for byte loads and stores
  localparam int FIELD_POS  = 0;
  localparam int RM_POS     = 0;  // Within the operand field
  localparam int SHTYPE_POS = 5;
  localparam int SHAMT_POS  = 7;  // 5-bit amount
  localparam int ROT_POS    = 8;  // 4-bit rotate count

  localparam int    DMEM_BYTES = 256;
  localparam word_t PC_STEP    = 32'd4;
  localparam word_t RESET_PC   = 32'd0;

endpackage

`default_nettype wire
